// ==== hw/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Backing memory size in words
`define MEM_WORDS 256
`define MEM_ADDR_BITS 8

// Line geometry
`define WORDS_PER_LINE 4
`define WORD_BITS 32
`define OFFSET_BITS 2

// Direct-mapped cache geometry
`define CACHE_LINES 8
`define INDEX_BITS 3
`define TAG_BITS 3

// Cycles from fill request to fill response
`define FILL_LATENCY 5
`define COUNT_BITS 16

`endif

// ==== hw/cache_pkg.sv ====
`include "cache_consts.svh"

package cache_pkg;

  // Data widths
  typedef logic [`WORD_BITS-1:0] word_t;

  // Word 0 sits in the low bits of a line
  typedef logic [`WORDS_PER_LINE*`WORD_BITS-1:0] line_t;

  // ----------------------------------------------------------------------------
  // Address fields, tag | index | offset from high to low
  // ----------------------------------------------------------------------------
  typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;
  typedef logic [`OFFSET_BITS-1:0] offset_t;
  typedef logic [`INDEX_BITS-1:0] index_t;
  typedef logic [`TAG_BITS-1:0] tag_t;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE,
    FILL_WAIT,
    RESPOND
  } ctrl_state_t;

  // Statistics
  typedef logic [`COUNT_BITS-1:0] count_t;

endpackage

// ==== hw/mem_if.sv ====
// Cache controller to backing memory
interface mem_if;
  import cache_pkg::*;

  // Request side, one-cycle strobe
  logic      req;
  logic      store;
  mem_addr_t address;
  word_t     store_data;

  // Fill response, valid for one cycle
  line_t     fill_data;
  logic      response_valid;

  modport ctrl (
    output req,
    output store,
    output address,
    output store_data,
    input  fill_data,
    input  response_valid
  );

  modport mem (
    input  req,
    input  store,
    input  address,
    input  store_data,
    output fill_data,
    output response_valid
  );

endinterface

// ==== hw/line_memory.sv ====
`include "cache_consts.svh"

module line_memory (
  input logic clk,
  input logic arst_n,
  mem_if.mem  mem
);
  import cache_pkg::*;

  localparam int LINES = `MEM_WORDS / `WORDS_PER_LINE;

  word_t storage [`MEM_WORDS];

  logic [$clog2(LINES)-1:0] line_sel;
  line_t                    fill_line;
  logic                     fill_load;

  // Transfer delay pipeline whose last stage feeds the response
  logic [`FILL_LATENCY-1:0] pipe_valid;
  line_t                    pipe_data [`FILL_LATENCY];

  // ----------------------------------------------------------------------------
  // Word storage
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        storage[i] <= '0;
      end
    end else if (mem.req && mem.store) begin
      storage[mem.address] <= mem.store_data;
    end
  end

  // Gather the line that holds the requested word
  assign line_sel = mem.address[`MEM_ADDR_BITS-1:`OFFSET_BITS];

  always_comb begin
    fill_line = '0;
    for (int w = 0; w < `WORDS_PER_LINE; w++) begin
      fill_line[w*`WORD_BITS +: `WORD_BITS] = storage[line_sel * `WORDS_PER_LINE + w];
    end
  end

  assign fill_load = mem.req && !mem.store;

  // ----------------------------------------------------------------------------
  // Delay pipeline
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid <= {pipe_valid[`FILL_LATENCY-2:0], fill_load};
    end
  end

  // Line contents are taken at the request edge
  always_ff @(posedge clk) begin
    pipe_data[0] <= fill_line;
    for (int s = 1; s < `FILL_LATENCY; s++) begin
      pipe_data[s] <= pipe_data[s-1];
    end
  end

  assign mem.response_valid = pipe_valid[`FILL_LATENCY-1];
  assign mem.fill_data      = pipe_data[`FILL_LATENCY-1];

endmodule

// ==== hw/cache_array.sv ====
`include "cache_consts.svh"

module cache_array (
  input  logic                 clk,
  input  logic                 arst_n,
  input  cache_pkg::mem_addr_t address,
  output logic                 hit,
  output cache_pkg::word_t     rdata,
  input  logic                 word_we,
  input  cache_pkg::word_t     wdata,
  input  logic                 line_we,
  input  cache_pkg::line_t     line_data
);
  import cache_pkg::*;

  // Address split
  tag_t    addr_tag;
  index_t  addr_index;
  offset_t addr_offset;

  // Storage, only the valid bits are reset
  line_t                  data_mem [`CACHE_LINES];
  tag_t                   tag_mem  [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid;

  line_t read_line;

  assign {addr_tag, addr_index, addr_offset} = address;

  // ----------------------------------------------------------------------------
  // Lookup
  // ----------------------------------------------------------------------------
  assign hit = valid[addr_index] && (tag_mem[addr_index] == addr_tag);

  // Incoming fill is forwarded while it is being installed
  assign read_line = line_we ? line_data : data_mem[addr_index];
  assign rdata     = read_line[addr_offset*`WORD_BITS +: `WORD_BITS];

  // ----------------------------------------------------------------------------
  // Update
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (line_we) begin
      data_mem[addr_index] <= line_data;
      tag_mem[addr_index]  <= addr_tag;
    end else if (word_we) begin
      data_mem[addr_index][addr_offset*`WORD_BITS +: `WORD_BITS] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (line_we) begin
      valid[addr_index] <= 1'b1;
    end
  end

  // Controller never writes a word while a fill is installed
  a_single_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(word_we && line_we)
  ) else $error("cache_array: word and line write in the same cycle");

endmodule

// ==== hw/cache_ctrl.sv ====
module cache_ctrl (
  input  logic                 clk,
  input  logic                 arst_n,

  // CPU side
  input  logic                 cpu_req,
  input  logic                 cpu_we,
  input  cache_pkg::mem_addr_t cpu_addr,
  input  cache_pkg::word_t     cpu_wdata,
  output logic                 cpu_busy,
  output logic                 cpu_ready,
  output cache_pkg::word_t     cpu_rdata,

  // Backing memory
  mem_if.ctrl                  mem,

  // Cache array
  output cache_pkg::mem_addr_t array_address,
  input  logic                 array_hit,
  input  cache_pkg::word_t     array_rdata,
  output logic                 word_we,
  output logic                 line_we,

  // Statistics
  output logic                 hit_pulse,
  output logic                 miss_pulse
);
  import cache_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  mem_addr_t addr_q;
  word_t     rdata_q;
  logic      accept;

  assign accept = (state_q == IDLE) && cpu_req;

  // Lookups use the live address only while idle
  assign array_address = (state_q == IDLE) ? cpu_addr : addr_q;

  // Stores go straight through to memory
  assign mem.address    = cpu_addr;
  assign mem.store_data = cpu_wdata;

  // ----------------------------------------------------------------------------
  // Next state and strobes
  // ----------------------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    mem.req    = 1'b0;
    mem.store  = 1'b0;
    word_we    = 1'b0;
    line_we    = 1'b0;
    hit_pulse  = 1'b0;
    miss_pulse = 1'b0;
    case (state_q)
      IDLE: begin
        if (cpu_req) begin
          if (cpu_we) begin
            // No allocate on a store miss
            mem.req   = 1'b1;
            mem.store = 1'b1;
            word_we   = array_hit;
            state_d   = RESPOND;
          end else if (array_hit) begin
            hit_pulse = 1'b1;
            state_d   = RESPOND;
          end else begin
            mem.req    = 1'b1;
            miss_pulse = 1'b1;
            state_d    = FILL_WAIT;
          end
        end
      end
      FILL_WAIT: begin
        if (mem.response_valid) begin
          line_we = 1'b1;
          state_d = RESPOND;
        end
      end
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and read data registers
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= cpu_addr;
    end
    if ((accept && !cpu_we) || line_we) begin
      rdata_q <= array_rdata;
    end
  end

  assign cpu_busy  = (state_q != IDLE);
  assign cpu_ready = (state_q == RESPOND);
  assign cpu_rdata = rdata_q;

  // ----------------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------------
  a_ready_one_cycle: assert property (
    @(posedge clk) disable iff (!arst_n)
    cpu_ready |=> !cpu_ready
  ) else $error("cache_ctrl: cpu_ready held for more than one cycle");

  a_req_when_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    mem.req |-> (state_q == IDLE)
  ) else $error("cache_ctrl: memory request outside IDLE");

endmodule

// ==== hw/access_counter.sv ====
module access_counter (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              hit_pulse,
  input  logic              miss_pulse,
  output cache_pkg::count_t hit_count,
  output cache_pkg::count_t miss_count
);
  import cache_pkg::*;

  // Stops at all ones instead of wrapping
  function automatic count_t sat_inc(input count_t value);
    if (value == '1) begin
      return value;
    end
    return value + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hit_count <= '0;
    end else if (hit_pulse) begin
      hit_count <= sat_inc(hit_count);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      miss_count <= '0;
    end else if (miss_pulse) begin
      miss_count <= sat_inc(miss_count);
    end
  end

  // A lookup is either a hit or a miss
  a_exclusive_pulses: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(hit_pulse && miss_pulse)
  ) else $error("access_counter: hit and miss pulse together");

endmodule

// ==== hw/cache_top.sv ====
module cache_top (
  input  logic                 clk,
  input  logic                 arst_n,

  // CPU port
  input  logic                 cpu_req,
  input  logic                 cpu_we,
  input  cache_pkg::mem_addr_t cpu_addr,
  input  cache_pkg::word_t     cpu_wdata,
  output logic                 cpu_busy,
  output logic                 cpu_ready,
  output cache_pkg::word_t     cpu_rdata,

  // Read statistics
  output cache_pkg::count_t    hit_count,
  output cache_pkg::count_t    miss_count
);
  import cache_pkg::*;

  mem_if mem_bus ();

  // Controller to array
  mem_addr_t array_address;
  logic      array_hit;
  word_t     array_rdata;
  logic      word_we;
  logic      line_we;

  logic hit_pulse;
  logic miss_pulse;

  // ----------------------------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------------------------
  cache_ctrl cache_ctrl_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .cpu_req       (cpu_req),
    .cpu_we        (cpu_we),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_busy      (cpu_busy),
    .cpu_ready     (cpu_ready),
    .cpu_rdata     (cpu_rdata),
    .mem           (mem_bus.ctrl),
    .array_address (array_address),
    .array_hit     (array_hit),
    .array_rdata   (array_rdata),
    .word_we       (word_we),
    .line_we       (line_we),
    .hit_pulse     (hit_pulse),
    .miss_pulse    (miss_pulse)
  );

  // Fill data goes straight into the array
  cache_array cache_array_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .address   (array_address),
    .hit       (array_hit),
    .rdata     (array_rdata),
    .word_we   (word_we),
    .wdata     (cpu_wdata),
    .line_we   (line_we),
    .line_data (mem_bus.fill_data)
  );

  line_memory line_memory_i (
    .clk    (clk),
    .arst_n (arst_n),
    .mem    (mem_bus.mem)
  );

  access_counter access_counter_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .hit_pulse  (hit_pulse),
    .miss_pulse (miss_pulse),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

endmodule

// ==== dv/cache_tb.sv ====
`include "cache_consts.svh"

module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int DIRECTED_OPS = 7;
  localparam int RANDOM_OPS   = 300;
  localparam int TOTAL_OPS    = DIRECTED_OPS + RANDOM_OPS;
  localparam int WAIT_LIMIT   = `FILL_LATENCY + 4;
  localparam int WATCHDOG_NS  = TOTAL_OPS * WAIT_LIMIT * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD;

  logic      clk;
  logic      arst_n;
  logic      cpu_req;
  logic      cpu_we;
  mem_addr_t cpu_addr;
  word_t     cpu_wdata;
  logic      cpu_busy;
  logic      cpu_ready;
  word_t     cpu_rdata;
  count_t    hit_count;
  count_t    miss_count;

  // Reference model state
  word_t                   model_mem [`MEM_WORDS];
  logic [`CACHE_LINES-1:0] tag_valid;
  int                      tag_model [`CACHE_LINES];
  count_t                  model_hits;
  count_t                  model_misses;

  // Expectation for the request in flight, age 0 means none
  int        age;
  int        exp_latency;
  logic      exp_read;
  word_t     exp_data;
  mem_addr_t exp_addr;
  int        done_count;

  int reset_errors = 0;
  int data_errors = 0;
  int timing_errors = 0;
  int wait_errors = 0;

  logic [15:0] lfsr_state;

  cache_top cache_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .cpu_req    (cpu_req),
    .cpu_we     (cpu_we),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_busy   (cpu_busy),
    .cpu_ready  (cpu_ready),
    .cpu_rdata  (cpu_rdata),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_step();
    logic feedback;
    feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], feedback};
    return feedback;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_step()};
    end
    return value;
  endfunction

  // Address is tag | index | offset
  function automatic int line_index_of(input mem_addr_t addr);
    return (int'(addr) / `WORDS_PER_LINE) % `CACHE_LINES;
  endfunction

  function automatic int tag_of(input mem_addr_t addr);
    return int'(addr) / (`WORDS_PER_LINE * `CACHE_LINES);
  endfunction

  // ------------------------------------------------------------------------
  // Reference model, follows requests the DUT accepts
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        model_mem[i] <= '0;
      end
      for (int i = 0; i < `CACHE_LINES; i++) begin
        tag_model[i] <= 0;
      end
      tag_valid    <= '0;
      model_hits   <= '0;
      model_misses <= '0;
      age          <= 0;
      exp_latency  <= 0;
      exp_read     <= 1'b0;
      exp_data     <= '0;
      exp_addr     <= '0;
      done_count   <= 0;
    end else begin
      if (cpu_ready) begin
        done_count <= done_count + 1;
      end
      if (cpu_req && !cpu_busy) begin
        age      <= 1;
        exp_addr <= cpu_addr;
        exp_read <= !cpu_we;
        if (cpu_we) begin
          model_mem[cpu_addr] <= cpu_wdata;
          exp_latency         <= 1;
        end else if (tag_valid[line_index_of(cpu_addr)] &&
                     tag_model[line_index_of(cpu_addr)] == tag_of(cpu_addr)) begin
          exp_data    <= model_mem[cpu_addr];
          exp_latency <= 1;
          model_hits  <= model_hits + 1'b1;
        end else begin
          exp_data     <= model_mem[cpu_addr];
          exp_latency  <= `FILL_LATENCY + 1;
          model_misses <= model_misses + 1'b1;
          tag_valid[line_index_of(cpu_addr)] <= 1'b1;
          tag_model[line_index_of(cpu_addr)] <= tag_of(cpu_addr);
        end
      end else if (cpu_ready) begin
        age <= 0;
      end else if (age != 0) begin
        age <= age + 1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  a_reset_state: assert property (
    @(posedge clk) $rose(arst_n) |->
      (!cpu_busy && !cpu_ready && hit_count == '0 && miss_count == '0)
  ) else begin
    reset_errors++;
    $display("[FAIL] %0d ns: outputs not idle or counters not zero after reset", $time);
  end

  a_read_data: assert property (
    @(posedge clk) disable iff (!arst_n)
    (cpu_ready && exp_read) |-> (cpu_rdata == exp_data)
  ) else begin
    data_errors++;
    $display("[FAIL] %0d ns: read of address %0d returned %h, expected %h",
             $time, exp_addr, cpu_rdata, exp_data);
  end

  a_ready_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    cpu_ready |-> (age == exp_latency)
  ) else begin
    timing_errors++;
    $display("[FAIL] %0d ns: cpu_ready after %0d cycles, expected %0d",
             $time, age, exp_latency);
  end

  a_ready_needs_request: assert property (
    @(posedge clk) disable iff (!arst_n)
    cpu_ready |-> (age != 0)
  ) else begin
    timing_errors++;
    $display("[FAIL] %0d ns: cpu_ready without an accepted request", $time);
  end

  // Busy from the cycle after acceptance through the ready cycle
  a_busy_window: assert property (
    @(posedge clk) disable iff (!arst_n)
    cpu_busy == (age != 0)
  ) else begin
    timing_errors++;
    $display("[FAIL] %0d ns: cpu_busy is %0b, request age %0d", $time, cpu_busy, age);
  end

  a_bounded_wait: assert property (
    @(posedge clk) disable iff (!arst_n)
    age <= `FILL_LATENCY + 1
  ) else begin
    timing_errors++;
    $display("[FAIL] %0d ns: request still open after %0d cycles", $time, age);
  end

  a_counters: assert property (
    @(posedge clk) disable iff (!arst_n)
    (hit_count == model_hits) && (miss_count == model_misses)
  ) else begin
    data_errors++;
    $display("[FAIL] %0d ns: counters hit %0d miss %0d, expected hit %0d miss %0d",
             $time, hit_count, miss_count, model_hits, model_misses);
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic run_op(input logic we, input mem_addr_t addr, input word_t data,
                        input logic stray);
    int done_before;
    int cycles;
    done_before = done_count;
    cpu_req   = 1'b1;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = data;
    @(posedge clk);
    #1;
    cpu_req = 1'b0;
    // A second store while busy, which the DUT must drop
    if (stray) begin
      cpu_req   = 1'b1;
      cpu_we    = 1'b1;
      cpu_addr  = {2'b00, addr[5:0] ^ 6'h21};
      cpu_wdata = ~data;
      @(posedge clk);
      #1;
      cpu_req = 1'b0;
    end
    cycles = 0;
    while (done_count == done_before && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (done_count == done_before) begin
      wait_errors++;
      $display("Request to address %0d got no cpu_ready within %0d cycles", addr, cycles);
    end
  endtask

  initial begin
    logic      is_store;
    mem_addr_t addr;
    word_t     data;
    logic      stray;
    lfsr_state = 16'd87;
    arst_n     = 1'b0;
    cpu_req    = 1'b0;
    cpu_we     = 1'b0;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;

    // Store hit, store miss and a conflicting line on index 2
    run_op(1'b0, 8'd5, '0, 1'b0);
    run_op(1'b1, 8'd5, random_bits(32), 1'b1);
    run_op(1'b0, 8'd5, '0, 1'b0);
    run_op(1'b1, 8'd40, random_bits(32), 1'b0);
    run_op(1'b0, 8'd40, '0, 1'b0);
    run_op(1'b0, 8'd8, '0, 1'b0);
    run_op(1'b0, 8'd40, '0, 1'b1);

    for (int n = 0; n < RANDOM_OPS; n++) begin
      is_store = (random_bits(2) == 0);
      addr     = mem_addr_t'(random_bits(6));
      data     = random_bits(32);
      stray    = (random_bits(2) == 0);
      run_op(is_store, addr, data, stray);
    end

    repeat (2) @(posedge clk);
    #1;
    $display("Error counts: reset %0d, data %0d, timing %0d, wait %0d",
             reset_errors, data_errors, timing_errors, wait_errors);
    if (reset_errors + data_errors + timing_errors + wait_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all requests completed");
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/cache_pkg.sv
hw/mem_if.sv
hw/line_memory.sv
hw/cache_array.sv
hw/cache_ctrl.sv
hw/access_counter.sv
hw/cache_top.sv
dv/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cache testbench with Verilator and runs it once
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module cache_tb \
  -f verilog.f

# A simulator abort still reaches the search below
sim_output="$(./obj_dir/Vcache_tb || true)"
printf '%s\n' "$sim_output"

if grep -qx "Test OK" <<< "$sim_output"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
